/* include/sparcCtl_config.svh */
/* SPARC_NWINDOWS must be a power of two from 2 to 32, and SPARC_CWP_W must be its log2.
   CWP arithmetic wraps by truncation to SPARC_CWP_W bits. */
`ifndef SPARC_CTL_CONFIG_SVH
`define SPARC_CTL_CONFIG_SVH

// number of register windows
`define SPARC_NWINDOWS 8

// CWP width, log2 of the window count
`define SPARC_CWP_W 3

// low bit of the 4-bit cond field in Bicc and Ticc, bits 28:25
`define SPARC_COND_LSB 25

`endif

/* design/sparcCtlPkg.sv */
/* Shared types for the control sequencer. Widths come from the config header.
   Trap codes are per result only, and there is no trap queue behind them. */
`include "sparcCtl_config.svh"

package sparcCtlPkg;

        typedef logic [`SPARC_CWP_W-1:0]    cwp_t;
        typedef logic [`SPARC_NWINDOWS-1:0] wimMask_t; // bit i set marks window i invalid

        typedef struct packed {
                logic n;
                logic z;
                logic v;
                logic c;
        } icc_t;

        typedef struct packed {
                logic [31:0] instr;
                icc_t        icc;   // flags valid for this instruction
        } instrReq_t;

        typedef enum logic [3:0] {
                opCall,
                opBranch,
                opSethi,
                opAlu,
                opJmpl,
                opRett,
                opSave,
                opRestore,
                opTicc,
                opLoad,
                opStore,
                opIllegal
        } opClass_e;

        typedef enum logic [2:0] {
                trNone,
                trWinOverflow,
                trWinUnderflow,
                trTicc,
                trIllegal
        } trap_e;

        typedef struct packed {
                opClass_e opClass;
                logic     taken;   // cond result, Bicc and Ticc only
                trap_e    trap;
                cwp_t     cwp;     // window pointer after the instruction
        } ctlResult_t;

endpackage

/* design/instrIntake.sv */
/* Input register stage. Holds one instruction and issues it when the result
   queue has room. A load and an issue can happen in the same cycle. */
`timescale 1ns/1ps

module instrIntake
(
        input  logic                   Clk,
        input  logic                   rstN,
        input  logic                   inValid,
        output logic                   inReady,
        input  sparcCtlPkg::instrReq_t inReq,
        input  logic                   pushReady,
        output logic                   stageValid,
        output sparcCtlPkg::instrReq_t stageReq,
        output logic                   issue
);

        logic                   stageFull;
        logic                   load;
        sparcCtlPkg::instrReq_t stageReg;

        assign issue      = stageFull && pushReady;   // single commit strobe
        assign inReady    = !stageFull || issue;      // empty, or emptying now
        assign load       = inValid && inReady;
        assign stageValid = stageFull;
        assign stageReq   = stageReg;

        always_ff @(posedge Clk or negedge rstN)
        begin
                if (!rstN)
                        stageFull <= 1'b0;
                else if (load)
                        stageFull <= 1'b1;
                else if (issue)
                        stageFull <= 1'b0;
        end

        always_ff @(posedge Clk)
        begin
                if (load)
                        stageReg <= inReq;   // payload only
        end

        // producer must hold the request while stalled
        inReqStable: assert property (@(posedge Clk) disable iff (!rstN)
                inValid && !inReady |=> !inValid || $stable(inReq))
                else $error("inReq changed while inValid was high and inReady low");

endmodule

/* design/iccEval.sv */
/* SPARC integer condition table. Codes 9 to 15 invert codes 1 to 7,
   so code 8 (always) is the inverse of code 0 (never). */
`timescale 1ns/1ps

module iccEval
(
        input  logic [3:0]        cond,
        input  sparcCtlPkg::icc_t icc,
        output logic              condTrue
);

        logic base;   // result of the low three bits

        always_comb
        begin
                case (cond[2:0])
                        3'd0: base = 1'b0;                           // never
                        3'd1: base = icc.z;                          // e
                        3'd2: base = icc.z | (icc.n ^ icc.v);        // le
                        3'd3: base = icc.n ^ icc.v;                  // l
                        3'd4: base = icc.c | icc.z;                  // leu
                        3'd5: base = icc.c;                          // cs
                        3'd6: base = icc.n;                          // neg
                        default: base = icc.v;                       // vs
                endcase
        end

        // upper half of the table is the negation
        assign condTrue = base ^ cond[3];

endmodule

/* design/opDecoder.sv */
/* Combinational decode of op, op2 and op3. PSR, WIM and TBR writes decode as
   illegal. Trap priority is illegal, then window, then Ticc. */
`timescale 1ns/1ps

module opDecoder
(
        input  sparcCtlPkg::instrReq_t  stageReq,
        input  logic                    condTrue,
        input  sparcCtlPkg::trap_e      winTrap,
        input  sparcCtlPkg::cwp_t       nextCwp,
        output sparcCtlPkg::opClass_e   opClass,
        output sparcCtlPkg::ctlResult_t result
);

        logic [1:0]         op;
        logic [2:0]         op2;
        logic [5:0]         op3;
        logic               taken;
        sparcCtlPkg::trap_e trap;

        assign op  = stageReq.instr[31:30];
        assign op2 = stageReq.instr[24:22];   // format 2 only
        assign op3 = stageReq.instr[24:19];   // formats 3

        always_comb
        begin
                case (op)
                        2'd0:
                        begin
                                case (op2)
                                        3'd4:    opClass = sparcCtlPkg::opSethi;
                                        3'd2:    opClass = sparcCtlPkg::opBranch;
                                        default: opClass = sparcCtlPkg::opIllegal;
                                endcase
                        end
                        2'd1:
                                opClass = sparcCtlPkg::opCall;
                        2'd2:
                        begin
                                case (op3)
                                        6'b111000: opClass = sparcCtlPkg::opJmpl;
                                        6'b111001: opClass = sparcCtlPkg::opRett;
                                        6'b111100: opClass = sparcCtlPkg::opSave;
                                        6'b111101: opClass = sparcCtlPkg::opRestore;
                                        6'b111010: opClass = sparcCtlPkg::opTicc;
                                        // WRPSR, WRWIM, WRTBR
                                        6'b110001,
                                        6'b110010,
                                        6'b110011: opClass = sparcCtlPkg::opIllegal;
                                        default:   opClass = sparcCtlPkg::opAlu;
                                endcase
                        end
                        default:   // op 3, memory
                        begin
                                if (stageReq.instr[21])
                                        opClass = sparcCtlPkg::opStore;
                                else
                                        opClass = sparcCtlPkg::opLoad;
                        end
                endcase
        end

        assign taken = (opClass == sparcCtlPkg::opBranch || opClass == sparcCtlPkg::opTicc)
                       ? condTrue : 1'b0;

        always_comb
        begin
                if (opClass == sparcCtlPkg::opIllegal)
                        trap = sparcCtlPkg::trIllegal;
                else if (winTrap != sparcCtlPkg::trNone)
                        trap = winTrap;
                else if (opClass == sparcCtlPkg::opTicc && taken)
                        trap = sparcCtlPkg::trTicc;
                else
                        trap = sparcCtlPkg::trNone;
        end

        assign result = '{opClass: opClass, taken: taken, trap: trap, cwp: nextCwp};

endmodule

/* design/windowCtl.sv */
/* Holds CWP and checks WIM for SAVE, RESTORE and RETT. A window trap leaves CWP
   as it was and no trap entry follows. WIM may change only while idle. */
`timescale 1ns/1ps
`include "sparcCtl_config.svh"

module windowCtl
(
        input  logic                  Clk,
        input  logic                  rstN,
        input  logic                  issue,
        input  sparcCtlPkg::opClass_e opClass,
        input  sparcCtlPkg::wimMask_t wim,
        output sparcCtlPkg::trap_e    winTrap,
        output sparcCtlPkg::cwp_t     nextCwp
);

        sparcCtlPkg::cwp_t cwp;
        sparcCtlPkg::cwp_t cwpDec;
        sparcCtlPkg::cwp_t cwpInc;

        // truncation gives the wrap modulo the window count
        assign cwpDec = cwp - 1'b1;
        assign cwpInc = cwp + 1'b1;

        always_comb
        begin
                winTrap = sparcCtlPkg::trNone;
                nextCwp = cwp;
                case (opClass)
                        sparcCtlPkg::opSave:
                        begin
                                if (wim[cwpDec])
                                        winTrap = sparcCtlPkg::trWinOverflow;
                                else
                                        nextCwp = cwpDec;
                        end
                        sparcCtlPkg::opRestore,
                        sparcCtlPkg::opRett:
                        begin
                                if (wim[cwpInc])
                                        winTrap = sparcCtlPkg::trWinUnderflow;
                                else
                                        nextCwp = cwpInc;
                        end
                        default: ;   // other classes keep CWP
                endcase
        end

        always_ff @(posedge Clk or negedge rstN)
        begin
                if (!rstN)
                        cwp <= '0;
                else if (issue)
                        cwp <= nextCwp;
        end

        cwpInRange: assert property (@(posedge Clk) disable iff (!rstN)
                cwp < `SPARC_NWINDOWS)
                else $error("CWP beyond window count");

endmodule

/* design/resultQueue.sv */
/* Two-entry result FIFO. pushReady is low only while both entries are full,
   so a pop in the same cycle does not free room for a push. */
`timescale 1ns/1ps

module resultQueue
(
        input  logic                    Clk,
        input  logic                    rstN,
        input  logic                    push,
        input  sparcCtlPkg::ctlResult_t pushData,
        output logic                    pushReady,
        output logic                    outValid,
        input  logic                    outReady,
        output sparcCtlPkg::ctlResult_t outRes
);

        sparcCtlPkg::ctlResult_t mem [2];
        logic                    rdPtr;
        logic                    wrPtr;
        logic [1:0]              count;
        logic                    pop;

        assign pushReady = (count != 2'd2);
        assign outValid  = (count != 2'd0);
        assign outRes    = mem[rdPtr];   // head entry
        assign pop       = outValid && outReady;

        always_ff @(posedge Clk or negedge rstN)
        begin
                if (!rstN)
                begin
                        rdPtr <= 1'b0;
                        wrPtr <= 1'b0;
                        count <= 2'd0;
                end
                else
                begin
                        if (push)
                                wrPtr <= ~wrPtr;
                        if (pop)
                                rdPtr <= ~rdPtr;
                        if (push && !pop)
                                count <= count + 2'd1;
                        else if (pop && !push)
                                count <= count - 2'd1;
                end
        end

        always_ff @(posedge Clk)
        begin
                if (push)
                        mem[wrPtr] <= pushData;
        end

        noPushWhenFull: assert property (@(posedge Clk) disable iff (!rstN)
                push |-> count != 2'd2)
                else $error("push into a full result queue");

endmodule

/* design/sparcCtlTop.sv */
/* Control sequencer top. One instruction in the intake stage, up to two results
   queued. wim must stay constant while any instruction is in flight. */
`timescale 1ns/1ps
`include "sparcCtl_config.svh"

module sparcCtlTop
(
        input  logic                    Clk,
        input  logic                    rstN,
        input  logic                    inValid,
        output logic                    inReady,
        input  sparcCtlPkg::instrReq_t  inReq,
        input  sparcCtlPkg::wimMask_t   wim,
        output logic                    outValid,
        input  logic                    outReady,
        output sparcCtlPkg::ctlResult_t outRes
);

        sparcCtlPkg::instrReq_t  stageReq;
        logic                    pushReady;
        logic                    issue;
        logic                    condTrue;
        sparcCtlPkg::opClass_e   opClass;
        sparcCtlPkg::trap_e      winTrap;
        sparcCtlPkg::cwp_t       nextCwp;
        sparcCtlPkg::ctlResult_t result;

        instrIntake i_intake (.Clk, .rstN, .inValid, .inReady, .inReq, .pushReady,
                .stageValid(), .stageReq, .issue);

        iccEval i_icc (.cond(stageReq.instr[`SPARC_COND_LSB +: 4]), .icc(stageReq.icc),
                .condTrue);

        opDecoder i_dec (.stageReq, .condTrue, .winTrap, .nextCwp, .opClass, .result);

        windowCtl i_win (.Clk, .rstN, .issue, .opClass, .wim, .winTrap, .nextCwp);

        resultQueue i_queue (.Clk, .rstN, .push(issue), .pushData(result), .pushReady,
                .outValid, .outReady, .outRes);

endmodule

/* testbench/sparcCtlTb.sv */
/* Random stimulus from seed 32'hc293, checked against a model of the decode,
   condition and window rules. wim is changed only after the DUT has drained. */
`timescale 1ns/1ps
`include "sparcCtl_config.svh"

module sparcCtlTb;

        localparam int numInstr = 400;
        localparam int blockLen = 40;   // instructions between wim changes

        logic                    Clk;
        logic                    rstN;
        logic                    inValid;
        logic                    inReady;
        sparcCtlPkg::instrReq_t  inReq;
        sparcCtlPkg::wimMask_t   wim;
        logic                    outValid;
        logic                    outReady;
        sparcCtlPkg::ctlResult_t outRes;

        integer                  seed;
        sparcCtlPkg::ctlResult_t expQ [$];   // expected results in accept order
        sparcCtlPkg::cwp_t       modelCwp;
        logic                    pending;    // inValid up, not yet accepted
        int                      offered;
        int                      sendLimit;

        sparcCtlTop i_dut (.Clk, .rstN, .inValid, .inReady, .inReq, .wim, .outValid,
                .outReady, .outRes);

        initial
        begin
                Clk = 1'b0;
                forever #10 Clk = ~Clk;
        end

        initial
        begin
                #(numInstr * 20 * 20);
                $display("Timeout: results stopped arriving from the DUT");
                abortRun();
        end

        task automatic abortRun();
                $display("Something failed");
                $fatal(1, "run stopped at the first error");
        endtask

        task automatic checkOpClass(input string name, input sparcCtlPkg::opClass_e exp, act);
                if (act !== exp)
                begin
                        $display("ERROR at %0t: %s expected %s, got %s (%0d)", $time, name,
                                exp.name(), act.name(), act);
                        abortRun();
                end
        endtask

        task automatic checkTrap(input string name, input sparcCtlPkg::trap_e exp, act);
                if (act !== exp)
                begin
                        $display("ERROR at %0t: %s expected %s, got %s (%0d)", $time, name,
                                exp.name(), act.name(), act);
                        abortRun();
                end
        endtask

        task automatic checkTaken(input string name, input logic exp, act);
                if (act !== exp)
                begin
                        $display("ERROR at %0t: %s expected %b, got %b", $time, name, exp, act);
                        abortRun();
                end
        endtask

        task automatic checkCwp(input string name, input sparcCtlPkg::cwp_t exp, act);
                if (act !== exp)
                begin
                        $display("ERROR at %0t: %s expected %0d, got %0d", $time, name, exp, act);
                        abortRun();
                end
        endtask

        task automatic checkFlag(input string name, input logic exp, act);
                if (act !== exp)
                begin
                        $display("ERROR at %0t: %s expected %b, got %b", $time, name, exp, act);
                        abortRun();
                end
        endtask

        function automatic sparcCtlPkg::opClass_e classify(input logic [31:0] w);
                case (w[31:30])
                        2'd0: return (w[24:22] == 3'd4) ? sparcCtlPkg::opSethi :
                                     (w[24:22] == 3'd2) ? sparcCtlPkg::opBranch :
                                     sparcCtlPkg::opIllegal;
                        2'd1: return sparcCtlPkg::opCall;
                        2'd3: return w[21] ? sparcCtlPkg::opStore : sparcCtlPkg::opLoad;
                        default: ;
                endcase
                if (w[24:19] == 6'b111000) return sparcCtlPkg::opJmpl;
                if (w[24:19] == 6'b111001) return sparcCtlPkg::opRett;
                if (w[24:19] == 6'b111100) return sparcCtlPkg::opSave;
                if (w[24:19] == 6'b111101) return sparcCtlPkg::opRestore;
                if (w[24:19] == 6'b111010) return sparcCtlPkg::opTicc;
                if (w[24:19] inside {[6'b110001:6'b110011]}) return sparcCtlPkg::opIllegal;
                return sparcCtlPkg::opAlu;
        endfunction

        function automatic logic condHolds(input logic [3:0] cond, input sparcCtlPkg::icc_t f);
                logic [7:0] truth;   // codes 0 to 7, upper half negated
                truth = {f.v, f.n, f.c, f.c | f.z, f.n ^ f.v, f.z | (f.n ^ f.v), f.z, 1'b0};
                return cond[3] ? ~truth[cond[2:0]] : truth[cond[2:0]];
        endfunction

        task automatic acceptModel(input sparcCtlPkg::instrReq_t req);
                sparcCtlPkg::ctlResult_t exp;
                sparcCtlPkg::trap_e      winTrap;
                int                      nextCwp;
                exp.opClass = classify(req.instr);
                exp.taken   = 1'b0;
                winTrap     = sparcCtlPkg::trNone;
                nextCwp     = modelCwp;
                if (exp.opClass inside {sparcCtlPkg::opBranch, sparcCtlPkg::opTicc})
                        exp.taken = condHolds(req.instr[`SPARC_COND_LSB +: 4], req.icc);
                if (exp.opClass == sparcCtlPkg::opSave)
                        nextCwp = (modelCwp + `SPARC_NWINDOWS - 1) % `SPARC_NWINDOWS;
                else if (exp.opClass inside {sparcCtlPkg::opRestore, sparcCtlPkg::opRett})
                        nextCwp = (modelCwp + 1) % `SPARC_NWINDOWS;
                if (nextCwp != modelCwp && wim[nextCwp])
                begin
                        winTrap = (exp.opClass == sparcCtlPkg::opSave) ?
                                  sparcCtlPkg::trWinOverflow : sparcCtlPkg::trWinUnderflow;
                        nextCwp = modelCwp;   // window stays put on a trap
                end
                if (exp.opClass == sparcCtlPkg::opIllegal)
                        exp.trap = sparcCtlPkg::trIllegal;
                else if (winTrap != sparcCtlPkg::trNone)
                        exp.trap = winTrap;
                else if (exp.opClass == sparcCtlPkg::opTicc && exp.taken)
                        exp.trap = sparcCtlPkg::trTicc;
                else
                        exp.trap = sparcCtlPkg::trNone;
                exp.cwp  = nextCwp[`SPARC_CWP_W-1:0];
                modelCwp = exp.cwp;
                expQ.push_back(exp);
        endtask

        // bias toward the listed op/op2/op3 codes
        task automatic makeReq(output sparcCtlPkg::instrReq_t req);
                logic [31:0] w;
                logic [31:0] r;
                w = $random(seed);
                r = $random(seed);
                case (r[3:0])
                        4'd0, 4'd1:  w[31:22] = {2'd0, w[29:25], 3'd2};       // Bicc
                        4'd2:        w[31:22] = {2'd0, w[29:25], 3'd4};       // SETHI
                        4'd3:        w[31:30] = 2'd0;                         // any op2
                        4'd4:        w[31:30] = 2'd1;                         // CALL
                        4'd5:        w[31:19] = {2'd2, w[29:25], 6'b111000};
                        4'd6:        w[31:19] = {2'd2, w[29:25], 6'b111001};
                        4'd7, 4'd8:  w[31:19] = {2'd2, w[29:25], 6'b111100};
                        4'd9, 4'd10: w[31:19] = {2'd2, w[29:25], 6'b111101};
                        4'd11, 4'd12: w[31:19] = {2'd2, w[29:25], 6'b111010};
                        4'd13:       w[31:19] = {2'd2, w[29:25], 6'b110001 + {4'd0, r[5:4] % 2'd3}};
                        4'd14:       w[31:30] = 2'd3;                         // load or store
                        default:     w[31:30] = 2'd2;                         // mostly ALU
                endcase
                req.instr = w;
                req.icc   = r[11:8];
        endtask

        // one clock: observe both transfers, then drive the next inputs
        task automatic tick(input bit allowSend, input bit newWim);
                sparcCtlPkg::ctlResult_t exp;
                sparcCtlPkg::instrReq_t  req;
                sparcCtlPkg::wimMask_t   mask;
                @(posedge Clk);
                if (outValid && outReady)
                begin
                        if (expQ.size() == 0)
                        begin
                                $display("The DUT delivered a result that no accepted instruction owes");
                                abortRun();
                        end
                        exp = expQ.pop_front();
                        checkOpClass("outRes.opClass", exp.opClass, outRes.opClass);
                        checkTaken("outRes.taken", exp.taken, outRes.taken);
                        checkTrap("outRes.trap", exp.trap, outRes.trap);
                        checkCwp("outRes.cwp", exp.cwp, outRes.cwp);
                end
                if (inValid && inReady)
                begin
                        acceptModel(inReq);
                        pending = 1'b0;
                end
                outReady <= ($random(seed) & 3) != 0;
                if (!pending && allowSend && offered < sendLimit && ($random(seed) & 3) != 0)
                begin
                        makeReq(req);
                        inReq   <= req;
                        inValid <= 1'b1;
                        pending  = 1'b1;
                        offered++;
                end
                else if (!pending)
                        inValid <= 1'b0;
                if (newWim)
                begin
                        for (int i = 0; i < `SPARC_NWINDOWS; i++)
                                mask[i] = ($random(seed) & 3) == 0;   // about a quarter set
                        wim <= mask;
                end
        endtask

        initial
        begin
                seed      = 32'hc293;
                rstN      = 1'b0;
                inValid   = 1'b0;
                inReq     = '0;
                wim       = '0;
                outReady  = 1'b0;
                modelCwp  = '0;
                pending   = 1'b0;
                offered   = 0;
                sendLimit = 0;
                repeat (5) @(posedge Clk);
                rstN <= 1'b1;
                @(negedge Clk);
                checkFlag("outValid", 1'b0, outValid);
                checkFlag("inReady", 1'b1, inReady);
                while (offered < numInstr)
                begin
                        while (pending || expQ.size() != 0)
                                tick(1'b0, 1'b0);
                        tick(1'b0, 1'b1);   // nothing in flight here
                        sendLimit += blockLen;
                        while (offered < sendLimit || pending)
                                tick(1'b1, 1'b0);
                end
                while (expQ.size() != 0)
                        tick(1'b0, 1'b0);
                // all results delivered, so the DUT must be idle with nothing left over
                @(negedge Clk);
                checkFlag("outValid", 1'b0, outValid);
                checkFlag("inReady", 1'b1, inReady);
                $display("Everything OK");
                $finish;
        end

endmodule

/* sparcCtl.f */
+incdir+include
design/sparcCtlPkg.sv
design/instrIntake.sv
design/iccEval.sv
design/opDecoder.sv
design/windowCtl.sv
design/resultQueue.sv
design/sparcCtlTop.sv
testbench/sparcCtlTb.sv

/* Bender.yml */
package:
  name: sparcCtl

export_include_dirs:
  - include

sources:
  - design/sparcCtlPkg.sv
  - design/instrIntake.sv
  - design/iccEval.sv
  - design/opDecoder.sv
  - design/windowCtl.sv
  - design/resultQueue.sv
  - design/sparcCtlTop.sv
  - target: test
    files:
      - testbench/sparcCtlTb.sv
